/* verilog/dac_pkg.sv */
// shared constants and types for the daisy-chained DAC controller, imported by every block
package dac_pkg;

    // ------------------------------
    // chain geometry
    // ------------------------------

    localparam int NUM_CHANNELS = 4;         // one dac per motor channel
    localparam int CHAN_W       = 2;         // channel index width
    localparam int WORD_W       = 32;        // one dac command word

    // channel and word types used on the internal link
    typedef logic [CHAN_W-1:0] chan_t;
    typedef logic [WORD_W-1:0] dac_word_t;

    // ------------------------------
    // dac command word fields
    // ------------------------------

    localparam logic [3:0]  DAC_CMD_WRU  = 4'h3;      // write input reg and update output
    localparam logic [3:0]  DAC_CMD_NOP  = 4'hF;      // no operation, dac ignores word
    localparam logic [15:0] DAC_VAL_INIT = 16'h8000;  // mid-scale, zero motor current

    // word layout is {8'h00, cmd, 4'h0, value}
    localparam dac_word_t NOP_WORD  = {8'h00, DAC_CMD_NOP, 4'h0, DAC_VAL_INIT};
    localparam dac_word_t INIT_WORD = 32'h00F0_8000;  // same bits as NOP_WORD

    // ------------------------------
    // host register address fields
    // ------------------------------

    // addr[15:12] module, addr[7:4] channel 1..4, addr[3:0] offset
    localparam logic [3:0] ADDR_MAIN    = 4'h0;   // main register module
    localparam logic [3:0] OFF_DAC_CTRL = 4'h1;   // dac control offset

    // ------------------------------
    // spi timing
    // ------------------------------

    localparam int SCLK_HALF  = 2;                          // sysclk cycles per sclk half
    localparam int SCLK_DIV_W = $clog2(2 * SCLK_HALF);      // divider counter width
    localparam int FRAME_BITS = NUM_CHANNELS * WORD_W;      // 128 bits per frame
    localparam int BIT_CNT_W  = $clog2(FRAME_BITS);         // frame bit counter width
    localparam int BIT_IDX_W  = $clog2(WORD_W);             // bit index within one word

endpackage

/* verilog/dac_link_if.sv */
// internal link between decoder, command store and spi serializer, bundled for the top level
`timescale 1ns/10ps

interface dac_link_if;
    import dac_pkg::*;

    logic      trig;     // frame start pulse, one cycle
    logic      busy;     // frame in progress
    logic      flush;    // overwrite word at chan with nop
    chan_t     chan;     // channel being fetched or flushed
    dac_word_t word;     // stored tx word for chan

    // host side decoder, raises trig and watches busy
    modport decoder (
        output trig,
        input  busy
    );

    // word store, serves fetches and takes flushes
    modport store (
        input  flush,
        input  chan,
        output word
    );

    // spi shifter, owns the frame timing
    modport serializer (
        input  trig,
        output busy,
        output flush,
        output chan,
        input  word
    );

endinterface

/* verilog/dac_reg_decode.sv */
// host write decoder, turns register writes and block strobes into channel writes and a trigger
`timescale 1ns/10ps

module dac_reg_decode (
    input  logic               sysclk,
    input  logic               arst_n,
    input  logic               reg_wen,     // quadlet write strobe
    input  logic               blk_wen,     // end of block write strobe
    input  logic [15:0]        reg_waddr,
    input  logic [31:0]        reg_wdata,   // only bits 15:0 carry the dac value
    output logic               wr_en,
    output dac_pkg::chan_t     wr_chan,
    output dac_pkg::dac_word_t wr_word,
    dac_link_if.decoder        link
);
    import dac_pkg::*;

    // ------------------------------
    // address decode
    // ------------------------------

    logic [3:0] chan_field;    // addr[7:4], channels numbered from 1
    logic       mod_hit;       // module and offset match
    logic       chan_ok;       // channel field in 1..NUM_CHANNELS
    logic       addr_hit;
    logic       trig_q;

    assign chan_field = reg_waddr[7:4];
    assign mod_hit    = (reg_waddr[15:12] == ADDR_MAIN) && (reg_waddr[3:0] == OFF_DAC_CTRL);
    assign chan_ok    = (chan_field != 4'd0) && (chan_field <= 4'(NUM_CHANNELS));
    assign addr_hit   = mod_hit && chan_ok;

    // ------------------------------
    // channel write
    // ------------------------------

    // writes landing during a frame are dropped, nothing queues them
    assign wr_en   = reg_wen && addr_hit && !link.busy;
    assign wr_chan = chan_t'(chan_field - 4'd1);         // host ch 1..4 -> index 0..3
    assign wr_word = {8'h00, DAC_CMD_WRU, 4'h0, reg_wdata[15:0]};

    // ------------------------------
    // frame trigger
    // ------------------------------

    // one cycle late so a quadlet write with both strobes
    // is already in the store when the frame fetches it
    always_ff @(posedge sysclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            trig_q <= 1'b0;
        end
        else
        begin
            trig_q <= blk_wen && addr_hit;   // bad address starts nothing
        end
    end

    assign link.trig = trig_q;

    // an idle serializer must answer the trigger on the next edge
    a_trig_starts_frame: assert property (@(posedge sysclk) disable iff (!arst_n)
        (link.trig && !link.busy) |=> link.busy);

endmodule

/* verilog/dac_cmd_store.sv */
// per-channel command word store with nop flush for the tx path and a sticky copy for readback
`timescale 1ns/10ps

module dac_cmd_store (
    input  logic               sysclk,
    input  logic               arst_n,
    input  logic               wr_en,       // accepted host write
    input  dac_pkg::chan_t     wr_chan,
    input  dac_pkg::dac_word_t wr_word,
    input  logic [15:0]        reg_raddr,
    output logic [31:0]        reg_rdata,
    output logic [15:0]        dac1,        // current command, channel 1
    output logic [15:0]        dac2,
    output logic [15:0]        dac3,
    output logic [15:0]        dac4,
    dac_link_if.store          link
);
    import dac_pkg::*;

    dac_word_t tx_mem   [NUM_CHANNELS];   // words for the next frame
    dac_word_t copy_mem [NUM_CHANNELS];   // last accepted write per channel

    logic [3:0] rd_field;                 // addr[7:4] of the read
    logic       rd_hit;
    chan_t      rd_chan;

    // ------------------------------
    // tx words
    // ------------------------------

    // flushed back to nop after each frame so a dac
    // only updates when the host wrote it again
    always_ff @(posedge sysclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < NUM_CHANNELS; i++)
            begin
                tx_mem[i] <= INIT_WORD;
            end
        end
        else if (link.flush)
        begin
            tx_mem[link.chan] <= NOP_WORD;
        end
        else if (wr_en)
        begin
            tx_mem[wr_chan] <= wr_word;
        end
    end

    assign link.word = tx_mem[link.chan];     // fetch for the serializer

    // ------------------------------
    // readback copies
    // ------------------------------

    always_ff @(posedge sysclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < NUM_CHANNELS; i++)
            begin
                copy_mem[i] <= INIT_WORD;
            end
        end
        else if (wr_en)
        begin
            copy_mem[wr_chan] <= wr_word;     // never touched by flush
        end
    end

    // channel 1..4 reads the copy, anything else reads zero
    assign rd_field  = reg_raddr[7:4];
    assign rd_hit    = (rd_field != 4'd0) && (rd_field <= 4'(NUM_CHANNELS));
    assign rd_chan   = chan_t'(rd_field - 4'd1);
    assign reg_rdata = rd_hit ? copy_mem[rd_chan] : 32'h0;

    // value field of each copy drives the current command outputs
    assign dac1 = copy_mem[0][15:0];
    assign dac2 = copy_mem[1][15:0];
    assign dac3 = copy_mem[2][15:0];
    assign dac4 = copy_mem[3][15:0];

    // flush only runs inside a frame and the decoder drops writes then
    a_flush_no_write: assert property (@(posedge sysclk) disable iff (!arst_n)
        !(link.flush && wr_en));

endmodule

/* verilog/dac_spi_chain.sv */
// spi serializer, shifts all four channel words through the dac daisy chain in one frame
`timescale 1ns/10ps

module dac_spi_chain (
    input  logic           sysclk,
    input  logic           arst_n,
    output logic           sclk,      // dac samples mosi on the rising edge
    output logic           mosi,
    output logic           csel,      // active low, frames the whole chain
    dac_link_if.serializer link
);
    import dac_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,                      // waiting for trig
        ST_LOAD,                      // one setup cycle, fetch channel 3
        ST_SHIFT,                     // 128 bits out
        ST_FLUSH                      // nop each channel, 0..3
    } state_t;

    state_t                state;
    logic [SCLK_DIV_W-1:0] div_cnt;   // sysclk cycles within one bit
    logic [BIT_CNT_W-1:0]  bit_cnt;   // bit position in the frame
    chan_t                 chan_q;    // next channel to fetch, or channel to flush
    dac_word_t             shreg;     // msb goes out first
    logic                  rise_now;  // sclk goes high next edge
    logic                  bit_end;   // last cycle of a bit
    logic                  word_end;  // last cycle of a word
    logic                  frame_end; // last cycle of bit 127

    // ------------------------------
    // bit timing
    // ------------------------------

    assign rise_now  = (state == ST_SHIFT) && (div_cnt == SCLK_DIV_W'(SCLK_HALF - 1));
    assign bit_end   = (state == ST_SHIFT) && (div_cnt == SCLK_DIV_W'(2 * SCLK_HALF - 1));
    assign word_end  = bit_end && (bit_cnt[BIT_IDX_W-1:0] == '1);
    assign frame_end = bit_end && (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1));

    // ------------------------------
    // frame fsm
    // ------------------------------

    always_ff @(posedge sysclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state   <= ST_IDLE;
            div_cnt <= '0;
            bit_cnt <= '0;
            chan_q  <= '0;
            sclk    <= 1'b0;
            csel    <= 1'b1;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (link.trig)
                    begin
                        state  <= ST_LOAD;
                        csel   <= 1'b0;                     // falls together with busy
                        chan_q <= chan_t'(NUM_CHANNELS - 1); // far end of chain first
                    end
                end
                ST_LOAD:
                begin
                    state   <= ST_SHIFT;
                    div_cnt <= '0;
                    bit_cnt <= '0;
                    chan_q  <= chan_q - 1'b1;   // prefetch pointer for next word
                end
                ST_SHIFT:
                begin
                    div_cnt <= bit_end ? '0 : div_cnt + 1'b1;
                    if (rise_now)
                    begin
                        sclk <= 1'b1;
                    end
                    if (bit_end)
                    begin
                        sclk    <= 1'b0;        // mosi moves on this same edge
                        bit_cnt <= bit_cnt + 1'b1;
                        if (frame_end)
                        begin
                            state  <= ST_FLUSH;
                            csel   <= 1'b1;
                            chan_q <= '0;       // flush runs upward from 0
                        end
                        else if (word_end)
                        begin
                            chan_q <= chan_q - 1'b1;
                        end
                    end
                end
                ST_FLUSH:
                begin
                    chan_q <= chan_q + 1'b1;
                    if (chan_q == chan_t'(NUM_CHANNELS - 1))
                    begin
                        state <= ST_IDLE;       // busy drops after channel 3
                    end
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // ------------------------------
    // shift register
    // ------------------------------

    // zero fill, so mosi rests low once the last word is out
    always_ff @(posedge sysclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            shreg <= '0;
        end
        else if ((state == ST_LOAD) || (word_end && !frame_end))
        begin
            shreg <= link.word;                 // word for chan_q
        end
        else if (bit_end)
        begin
            shreg <= {shreg[WORD_W-2:0], 1'b0};
        end
    end

    assign mosi       = shreg[WORD_W-1];
    assign link.busy  = (state != ST_IDLE);
    assign link.flush = (state == ST_FLUSH);
    assign link.chan  = chan_q;

    // chip select must hold through load and all 128 bits
    a_csel_frame: assert property (@(posedge sysclk) disable iff (!arst_n)
        (link.busy && (state != ST_FLUSH)) |-> !csel);

    // no stray clock edge outside a frame
    a_sclk_idle: assert property (@(posedge sysclk) disable iff (!arst_n)
        csel |-> !sclk);

endmodule

/* verilog/dac_ctrl.sv */
// top level of the dac controller, ties the host register bus to the spi daisy chain
`timescale 1ns/10ps

module dac_ctrl (
    input  logic        sysclk,
    input  logic        arst_n,
    // host register bus
    input  logic        reg_wen,      // register write strobe
    input  logic        blk_wen,      // block write done, starts a frame
    input  logic [15:0] reg_raddr,
    input  logic [15:0] reg_waddr,
    input  logic [31:0] reg_wdata,
    output logic [31:0] reg_rdata,    // readback copy, combinational
    // spi to the dac chain
    output logic        sclk,
    output logic        mosi,
    output logic        csel,
    // current command per channel
    output logic [15:0] dac1,
    output logic [15:0] dac2,
    output logic [15:0] dac3,
    output logic [15:0] dac4
);
    import dac_pkg::*;

    logic      wr_en;      // accepted host write
    chan_t     wr_chan;
    dac_word_t wr_word;    // write-and-update word

    dac_link_if link ();   // trig, busy, flush, chan, word

    // ------------------------------
    // blocks
    // ------------------------------

    dac_reg_decode decode_i (
        .sysclk    (sysclk),
        .arst_n    (arst_n),
        .reg_wen   (reg_wen),
        .blk_wen   (blk_wen),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .wr_en     (wr_en),
        .wr_chan   (wr_chan),
        .wr_word   (wr_word),
        .link      (link.decoder)
    );

    dac_cmd_store store_i (
        .sysclk    (sysclk),
        .arst_n    (arst_n),
        .wr_en     (wr_en),
        .wr_chan   (wr_chan),
        .wr_word   (wr_word),
        .reg_raddr (reg_raddr),
        .reg_rdata (reg_rdata),
        .dac1      (dac1),
        .dac2      (dac2),
        .dac3      (dac3),
        .dac4      (dac4),
        .link      (link.store)
    );

    dac_spi_chain spi_i (
        .sysclk (sysclk),
        .arst_n (arst_n),
        .sclk   (sclk),
        .mosi   (mosi),
        .csel   (csel),
        .link   (link.serializer)
    );

endmodule

/* test/dac_ctrl_tb.sv */
// table-driven testbench for the dac controller, checks spi frames and readback against a model
`timescale 1ns/10ps

module dac_ctrl_tb;

    logic        sysclk;
    logic        arst_n;
    logic        reg_wen;
    logic        blk_wen;
    logic [15:0] reg_raddr;
    logic [15:0] reg_waddr;
    logic [31:0] reg_wdata;
    logic [31:0] reg_rdata;
    logic        sclk;
    logic        mosi;
    logic        csel;
    logic [15:0] dac1;
    logic [15:0] dac2;
    logic [15:0] dac3;
    logic [15:0] dac4;

    // ------------------------------
    // stimulus table and model
    // ------------------------------

    localparam int n_rows = 9;
    logic [3:0]  row_mask [n_rows];      // bit c writes channel c+1
    int          row_bad  [n_rows];      // 0 ok, 1 module, 2 offset, 3 chan 0, 4 chan 5
    logic        row_mid  [n_rows];      // extra write while csel is low
    logic [15:0] row_data [n_rows][4];   // filled from $random

    logic [31:0] tx_model   [4];         // words the next frame should carry
    logic [31:0] copy_model [4];         // last accepted write per channel
    integer      seed;
    int          errors;
    int          timeouts;
    int          checks;

    dac_ctrl dac_ctrl_i (
        .sysclk    (sysclk),
        .arst_n    (arst_n),
        .reg_wen   (reg_wen),
        .blk_wen   (blk_wen),
        .reg_raddr (reg_raddr),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .sclk      (sclk),
        .mosi      (mosi),
        .csel      (csel),
        .dac1      (dac1),
        .dac2      (dac2),
        .dac3      (dac3),
        .dac4      (dac4)
    );

    initial
    begin
        sysclk = 1'b0;
        forever #4 sysclk = ~sysclk;   // 8 ns period
    end

    // ------------------------------
    // helpers
    // ------------------------------

    task automatic tick();
        @(posedge sysclk);
        #1;                            // drive and sample 1 ns after the edge
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("FAIL %s got %h exp %h", name, got, exp);
        end
    endtask

    // write-and-update command, code 3 in bits 23:20
    function automatic logic [31:0] wru_word(input logic [15:0] val);
        return {8'h00, 4'h3, 4'h0, val};
    endfunction

    // module 0, channel field, offset 1, then one field spoiled
    function automatic logic [15:0] make_addr(input int chan_field, input int bad);
        logic [3:0] mod_f;
        logic [3:0] off_f;
        logic [3:0] ch_f;
        mod_f = 4'h0;
        off_f = 4'h1;
        ch_f  = chan_field[3:0];
        case (bad)
            1: mod_f = 4'h2;
            2: off_f = 4'h3;
            3: ch_f  = 4'h0;
            4: ch_f  = 4'h5;
            default: ;
        endcase
        return {mod_f, 4'h0, ch_f, off_f};
    endfunction

    task automatic write_chan(input int chan_field, input logic [15:0] val, input int bad);
        logic [31:0] junk;
        junk      = $random(seed);
        reg_waddr = make_addr(chan_field, bad);
        reg_wdata = {junk[31:16], val};   // upper half must be ignored
        reg_wen   = 1'b1;
        tick();
        reg_wen   = 1'b0;
    endtask

    task automatic block_strobe(input int bad);
        reg_waddr = make_addr(1, bad);
        blk_wen   = 1'b1;
        tick();
        blk_wen   = 1'b0;
    endtask

    task automatic check_readback();
        for (int ch = 1; ch <= 4; ch++)
        begin
            reg_raddr = {8'h00, ch[3:0], 4'h1};
            tick();
            check_word($sformatf("reg_rdata ch%0d", ch), reg_rdata, copy_model[ch-1]);
        end
        reg_raddr = 16'h0001;          // channel field 0
        tick();
        check_word("reg_rdata ch0", reg_rdata, 32'h0);
        reg_raddr = 16'h0051;          // channel field 5
        tick();
        check_word("reg_rdata ch5", reg_rdata, 32'h0);
        check_word("dac1", {16'h0, dac1}, {16'h0, copy_model[0][15:0]});
        check_word("dac2", {16'h0, dac2}, {16'h0, copy_model[1][15:0]});
        check_word("dac3", {16'h0, dac3}, {16'h0, copy_model[2][15:0]});
        check_word("dac4", {16'h0, dac4}, {16'h0, copy_model[3][15:0]});
    endtask

    task automatic wait_csel_low(input int limit, output logic ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while ((n < limit) && !ok)
        begin
            if (csel === 1'b0)
                ok = 1'b1;
            else
            begin
                tick();
                n++;
            end
        end
        if (!ok)
        begin
            timeouts++;
            $display("timeout: csel never fell after the block strobe");
        end
    endtask

    // one bit per sclk rising edge, optional dropped write at cycle 40
    task automatic capture_frame(input logic mid, output logic [127:0] stream, output int nbits);
        int   n;
        logic sclk_prev;
        stream    = '0;
        nbits     = 0;
        n         = 0;
        sclk_prev = sclk;
        while ((csel === 1'b0) && (n < 600))
        begin
            if (mid && (n == 40))
            begin
                reg_waddr = make_addr(1, 0);
                reg_wdata = {16'h0, ~copy_model[0][15:0]};   // differs from stored value
                reg_wen   = 1'b1;
            end
            if (n == 41)
                reg_wen = 1'b0;
            tick();
            n++;
            if ((sclk === 1'b1) && (sclk_prev === 1'b0))
            begin
                stream = {stream[126:0], mosi};
                nbits++;
            end
            sclk_prev = sclk;
        end
        reg_wen = 1'b0;
        if (csel !== 1'b1)
        begin
            timeouts++;
            $display("timeout: csel stayed low past the frame length");
        end
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------

    initial
    begin
        logic [31:0]  junk;
        logic [127:0] stream;
        int           nbits;
        logic         ok;
        logic         stray;

        seed      = 32'hdd37;
        errors    = 0;
        timeouts  = 0;
        checks    = 0;
        arst_n    = 1'b0;
        reg_wen   = 1'b0;
        blk_wen   = 1'b0;
        reg_raddr = 16'h0;
        reg_waddr = 16'h0;
        reg_wdata = 32'h0;

        // mask, address fault, write during frame
        row_mask = '{4'hF, 4'h0, 4'h0, 4'h5, 4'hA, 4'hF, 4'h3, 4'hC, 4'h6};
        row_bad  = '{0, 0, 0, 0, 1, 2, 3, 4, 0};
        row_mid  = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
        for (int r = 0; r < n_rows; r++)
        begin
            for (int c = 0; c < 4; c++)
            begin
                junk          = $random(seed);
                row_data[r][c] = junk[15:0];
            end
        end
        for (int c = 0; c < 4; c++)
        begin
            tx_model[c]   = 32'h00F0_8000;   // nop word at mid-scale
            copy_model[c] = 32'h00F0_8000;
        end

        repeat (2) @(posedge sysclk);
        #1;
        arst_n = 1'b1;

        // idle pins after reset
        check_word("csel", {31'h0, csel}, 32'h1);
        check_word("sclk", {31'h0, sclk}, 32'h0);
        check_word("mosi", {31'h0, mosi}, 32'h0);
        check_readback();
        tick();

        for (int r = 0; r < n_rows; r++)
        begin
            for (int c = 0; c < 4; c++)
            begin
                if (row_mask[r][c])
                begin
                    write_chan(c + 1, row_data[r][c], row_bad[r]);
                    if (row_bad[r] == 0)
                    begin
                        tx_model[c]   = wru_word(row_data[r][c]);
                        copy_model[c] = wru_word(row_data[r][c]);
                    end
                end
            end
            block_strobe(row_bad[r]);

            if (row_bad[r] != 0)
            begin
                stray = 1'b0;
                repeat (600)
                begin
                    tick();
                    if (csel !== 1'b1)
                        stray = 1'b1;
                end
                checks++;
                assert (!stray)
                else
                begin
                    errors++;
                    $display("a strobe with a bad address started a frame in row %0d", r);
                end
            end
            else
            begin
                wait_csel_low(20, ok);
                if (ok)
                begin
                    capture_frame(row_mid[r], stream, nbits);
                    check_word("sclk rising edges", nbits, 32'd128);
                    checks++;
                    assert (stream === {tx_model[3], tx_model[2], tx_model[1], tx_model[0]})
                    else
                    begin
                        errors++;
                        $display("FAIL mosi stream got %h exp %h", stream,
                            {tx_model[3], tx_model[2], tx_model[1], tx_model[0]});
                    end
                end
                repeat (6) tick();   // four flush cycles then idle
                for (int c = 0; c < 4; c++)
                    tx_model[c] = 32'h00F0_8000;
            end

            check_readback();
            tick();
        end

        $display("checks %0d errors %0d timeouts %0d", checks, errors, timeouts);
        if ((errors == 0) && (timeouts == 0))
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

/* project.f */
verilog/dac_pkg.sv
verilog/dac_link_if.sv
verilog/dac_reg_decode.sv
verilog/dac_cmd_store.sv
verilog/dac_spi_chain.sv
verilog/dac_ctrl.sv
test/dac_ctrl_tb.sv

/* run.sh */
#!/bin/sh
# build with verilator, run, and pass only if the simulation prints its pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module dac_ctrl_tb \
    --Mdir obj_dir -o dac_ctrl_sim \
    && ./obj_dir/dac_ctrl_sim | tee /dev/stderr | grep -q "TEST OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
